// ==== common/gx_video_pkg.sv ====
`default_nettype none

package gx_video_pkg;

    // ---------------------------------------------------------
    // CPU mode-write decode constants
    // ---------------------------------------------------------
    localparam logic [7:0] CRTC_PAGE       = 8'hBC;  // Address high byte for mode writes
    localparam logic [4:0] MODE_SEL_CONFIG = 5'd0;   // Low five data bits pick the target
    localparam logic [4:0] MODE_SEL_MRER   = 5'd1;
    localparam logic [4:0] MODE_SEL_ASIC   = 5'd2;

    // ASIC mode bytes that hand the video path to the ASIC
    localparam logic [7:0] ASIC_MODE_PALETTE = 8'h02;  // Palette lookup only
    localparam logic [7:0] ASIC_MODE_SPRITE  = 8'h62;  // Sprite priority over gate array
    localparam logic [7:0] ASIC_MODE_BLEND   = 8'h82;  // Half palette, half gate array

    localparam logic [3:0] SPRITE_PAGE = 4'hF;  // ma[13:10] inside the sprite window

    // ---------------------------------------------------------
    // Widths
    // ---------------------------------------------------------
    localparam int MA_W       = 14;  // CRTC memory address
    localparam int RA_W       = 5;   // CRTC row address
    localparam int PAL_ADDR_W = 14;  // ASIC palette RAM address

    // Gate-array colour, 2 bits per gun
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb2_t;

    // One CRTC beat as seen by the colour stage
    typedef struct packed {
        logic [MA_W-1:0] ma;
        logic [RA_W-1:0] ra;
        logic            de;
        logic            hsync;
        logic            vsync;
    } crtc_beat_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic hblank;
        logic vblank;
    } sync_t;

    typedef enum logic [1:0] {
        MIX_PASS    = 2'd0,  // Gate-array colour, zero-extended
        MIX_PALETTE = 2'd1,  // Palette latch
        MIX_SPRITE  = 2'd2,  // Latch inside sprite window, else pass
        MIX_BLEND   = 2'd3   // (latch + pass) / 2
    } mix_sel_t;

    // Single-cycle CPU write, no acknowledge
    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
    } cpu_wr_t;

endpackage

`default_nettype wire

// ==== src/mode_decoder.sv ====
`default_nettype none

module mode_decoder
    import gx_video_pkg::*;
(
    input  wire          clk_sys,
    input  wire          reset,
    input  wire          plus_mode,          // Board strap, Plus hardware present
    input  wire cpu_wr_t cpu,
    output mix_sel_t     mix_sel,
    output logic         use_asic_palette,
    output logic         asic_enabled
);

    logic [7:0] config_mode;  // Zero keeps the classic colour path
    logic [4:0] mrer;         // Bit 0 selects the ASIC palette
    logic [7:0] asic_mode;
    logic       mode_wr;
    logic       asic_code;    // Data byte is one of the three ASIC modes

    assign mode_wr   = cpu.wr && (cpu.addr[15:8] == CRTC_PAGE) && !cpu.addr[0];
    assign asic_code = (cpu.data == ASIC_MODE_PALETTE) ||
                       (cpu.data == ASIC_MODE_SPRITE)  ||
                       (cpu.data == ASIC_MODE_BLEND);

    // ---------------------------------------------------------
    // Mode registers
    // ---------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            config_mode  <= 8'h00;
            mrer         <= 5'h00;
            asic_mode    <= 8'h00;
            asic_enabled <= 1'b0;
        end else begin
            if (mode_wr) begin
                case (cpu.data[4:0])
                    MODE_SEL_CONFIG: config_mode <= cpu.data;
                    MODE_SEL_MRER:   mrer        <= cpu.data[4:0];
                    MODE_SEL_ASIC: begin
                        asic_mode    <= cpu.data;
                        asic_enabled <= asic_code && plus_mode;
                    end
                    default: ;  // Other targets live elsewhere
                endcase
            end
            if (!plus_mode) asic_enabled <= 1'b0;  // Strap low drops the takeover
        end
    end

    // Mix selection straight from the stored modes
    always_comb begin
        if ((config_mode == 8'h00) || !asic_enabled) begin
            mix_sel = MIX_PASS;
        end else begin
            case (asic_mode)
                ASIC_MODE_SPRITE: mix_sel = MIX_SPRITE;
                ASIC_MODE_BLEND:  mix_sel = MIX_BLEND;
                default:          mix_sel = MIX_PALETTE;
            endcase
        end
    end

    assign use_asic_palette = asic_enabled && mrer[0];

    // ASIC takeover only follows a clock with the Plus strap high
    a_enable_needs_plus: assert property (
        @(posedge clk_sys) disable iff (reset) asic_enabled |-> $past(plus_mode)
    );

endmodule

`default_nettype wire

// ==== src/sprite_window.sv ====
`default_nettype none

module sprite_window
    import gx_video_pkg::*;
(
    input  wire             clk_sys,
    input  wire             reset,
    input  wire             cclk_en,
    input  wire crtc_beat_t crtc,
    output logic            sprite_active,      // First stage, used by the mixers
    output logic            sprite_active_out,
    output logic [3:0]      sprite_id_out
);

    logic [3:0] sprite_id;  // First-stage id

    // ---------------------------------------------------------
    // Two-stage flag and id pipeline, advances on beats only
    // ---------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sprite_active     <= 1'b0;
            sprite_id         <= 4'h0;
            sprite_active_out <= 1'b0;
            sprite_id_out     <= 4'h0;
        end else if (cclk_en) begin
            if (crtc.de) begin
                // Top four address bits mark the sprite page
                sprite_active     <= (crtc.ma[MA_W-1 -: 4] == SPRITE_PAGE);
                sprite_id         <= crtc.ma[9:6];  // Sprite number within the page
                sprite_active_out <= sprite_active;
                sprite_id_out     <= sprite_id;
            end else begin
                // Border or retrace, flush both stages
                sprite_active     <= 1'b0;
                sprite_id         <= 4'h0;
                sprite_active_out <= 1'b0;
                sprite_id_out     <= 4'h0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sync_select.sv ====
`default_nettype none

module sync_select
    import gx_video_pkg::*;
(
    input  wire             clk_sys,
    input  wire             reset,
    input  wire             cclk_en,
    input  wire             asic_enabled,
    input  wire crtc_beat_t crtc,
    input  wire sync_t      asic_sync_in,  // Straight from the ASIC timing pins
    output sync_t           sync_out,
    output logic            sync_filter     // High while ASIC timing is in use
);

    sync_t asic_sync_q;  // ASIC set, one beat behind the pins
    sync_t crtc_sync;    // Set rebuilt from the CRTC beat

    // Classic timing from the CRTC
    always_comb begin
        crtc_sync.hsync  = crtc.hsync;
        crtc_sync.vsync  = crtc.vsync;
        crtc_sync.hblank = !crtc.de;           // Blank wherever display is off
        crtc_sync.vblank = (crtc.ra == '0);    // First scan row of each character
    end

    // ---------------------------------------------------------
    // Input stage and selection, both on beats
    // ---------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            asic_sync_q <= '0;
            sync_out    <= '0;
            sync_filter <= 1'b0;
        end else if (cclk_en) begin
            asic_sync_q <= asic_sync_in;
            if (asic_enabled) begin
                sync_out    <= asic_sync_q;  // Plus timing
                sync_filter <= 1'b1;
            end else begin
                sync_out    <= crtc_sync;
                sync_filter <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mixer/palette_fetch.sv ====
`default_nettype none

module palette_fetch
    import gx_video_pkg::*;
(
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire                   cclk_en,
    input  wire                   asic_enabled,
    input  wire crtc_beat_t       crtc,
    input  wire [7:0]             asic_ram_q,     // Palette byte, bits 7:6 unused
    output logic [PAL_ADDR_W-1:0] asic_ram_addr,
    output logic                  asic_ram_rd,
    output rgb2_t                 pal_rgb
);

    logic [4:0] pen;  // Row bits over the low address bits

    assign pen = {crtc.ra[2:0], crtc.ma[1:0]};

    // ---------------------------------------------------------
    // Read request, one strobe per displayed beat
    // ---------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            asic_ram_addr <= '0;
            asic_ram_rd   <= 1'b0;
        end else begin
            asic_ram_rd <= 1'b0;  // Default low, pulse below
            if (cclk_en && crtc.de && asic_enabled) begin
                asic_ram_addr <= PAL_ADDR_W'(pen);  // Pens sit at the bottom of RAM
                asic_ram_rd   <= 1'b1;
            end
        end
    end

    // Split the returned byte per gun
    always_comb begin
        pal_rgb.r = asic_ram_q[1:0];
        pal_rgb.g = asic_ram_q[3:2];
        pal_rgb.b = asic_ram_q[5:4];
    end

    // Gate-array enable leaves at least one idle clock between beats
    a_rd_single: assert property (
        @(posedge clk_sys) disable iff (reset) asic_ram_rd |=> !asic_ram_rd
    );

endmodule

`default_nettype wire

// ==== mixer/channel_mixer.sv ====
`default_nettype none

module channel_mixer
    import gx_video_pkg::*;
#(
    parameter int CHANNEL_W = 4  // Output gun width
) (
    input  wire                  clk_sys,
    input  wire                  reset,
    input  wire                  cclk_en,
    input  wire                  de,
    input  wire                  sprite_active,
    input  wire                  use_asic_palette,
    input  wire mix_sel_t        mix_sel,
    input  wire [1:0]            pal_chan,   // From the palette RAM byte
    input  wire [1:0]            ga_chan,    // From the motherboard gate array
    output logic [CHANNEL_W-1:0] chan_out
);

    logic [1:0]           pal_latch;  // Colour chosen on the previous beat
    logic [CHANNEL_W-1:0] latch_ext;
    logic [CHANNEL_W-1:0] ga_ext;
    logic [CHANNEL_W:0]   blend_sum;  // One spare bit for the carry
    logic [CHANNEL_W-1:0] mix_val;

    assign latch_ext = CHANNEL_W'(pal_latch);
    assign ga_ext    = CHANNEL_W'(ga_chan);
    assign blend_sum = {1'b0, latch_ext} + {1'b0, ga_ext};

    // ---------------------------------------------------------
    // Colour mix
    // ---------------------------------------------------------
    always_comb begin
        case (mix_sel)
            MIX_PALETTE: mix_val = latch_ext;
            MIX_SPRITE:  mix_val = sprite_active ? latch_ext : ga_ext;  // Sprite on top
            MIX_BLEND:   mix_val = blend_sum[CHANNEL_W:1];              // Average of both
            default:     mix_val = ga_ext;                              // Classic CPC
        endcase
    end

    // Latch and output register, both on beats
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pal_latch <= 2'b00;
            chan_out  <= '0;
        end else if (cclk_en) begin
            pal_latch <= use_asic_palette ? pal_chan : ga_chan;
            if (de) begin
                chan_out <= mix_val;
            end else begin
                chan_out <= '0;  // Border is black
            end
        end
    end

    // Black one clock after an undisplayed beat
    a_black_border: assert property (
        @(posedge clk_sys) disable iff (reset) (cclk_en && !de) |=> (chan_out == '0)
    );

endmodule

`default_nettype wire

// ==== src/gx_video_top.sv ====
`default_nettype none

module gx_video_top
    import gx_video_pkg::*;
#(
    parameter int CHANNEL_W = 4
) (
    input  wire                   clk_sys,
    input  wire                   reset,
    input  wire                   plus_mode,
    input  wire                   cclk_en,          // Gate-array pixel enable
    input  wire cpu_wr_t          cpu,
    input  wire crtc_beat_t       crtc,
    input  wire rgb2_t            ga_rgb,
    input  wire sync_t            asic_sync_in,
    input  wire [7:0]             asic_ram_q,
    output logic [CHANNEL_W-1:0]  r_out,
    output logic [CHANNEL_W-1:0]  g_out,
    output logic [CHANNEL_W-1:0]  b_out,
    output logic                  sprite_active_out,
    output logic [3:0]            sprite_id_out,
    output sync_t                 sync_out,
    output logic                  sync_filter,
    output logic [PAL_ADDR_W-1:0] asic_ram_addr,
    output logic                  asic_ram_rd
);

    mix_sel_t             mix_sel;
    logic                 use_asic_palette;
    logic                 asic_enabled;
    logic                 sprite_active;  // First-stage window flag
    rgb2_t                pal_rgb;
    logic [CHANNEL_W-1:0] mix_out [3];    // r, g, b

    // ---------------------------------------------------------
    // Control
    // ---------------------------------------------------------
    mode_decoder u_mode_decoder (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .plus_mode        (plus_mode),
        .cpu              (cpu),
        .mix_sel          (mix_sel),
        .use_asic_palette (use_asic_palette),
        .asic_enabled     (asic_enabled)
    );

    sprite_window u_sprite_window (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .cclk_en           (cclk_en),
        .crtc              (crtc),
        .sprite_active     (sprite_active),
        .sprite_active_out (sprite_active_out),
        .sprite_id_out     (sprite_id_out)
    );

    sync_select u_sync_select (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .cclk_en      (cclk_en),
        .asic_enabled (asic_enabled),
        .crtc         (crtc),
        .asic_sync_in (asic_sync_in),
        .sync_out     (sync_out),
        .sync_filter  (sync_filter)
    );

    // ---------------------------------------------------------
    // Colour path
    // ---------------------------------------------------------
    palette_fetch u_palette_fetch (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .cclk_en       (cclk_en),
        .asic_enabled  (asic_enabled),
        .crtc          (crtc),
        .asic_ram_q    (asic_ram_q),
        .asic_ram_addr (asic_ram_addr),
        .asic_ram_rd   (asic_ram_rd),
        .pal_rgb       (pal_rgb)
    );

    // Channel 0 is red, sitting in the top bits of rgb2_t
    for (genvar ch = 0; ch < 3; ch++) begin : g_chan
        localparam int LSB = 4 - 2 * ch;

        channel_mixer #(
            .CHANNEL_W (CHANNEL_W)
        ) u_mixer (
            .clk_sys          (clk_sys),
            .reset            (reset),
            .cclk_en          (cclk_en),
            .de               (crtc.de),
            .sprite_active    (sprite_active),
            .use_asic_palette (use_asic_palette),
            .mix_sel          (mix_sel),
            .pal_chan         (pal_rgb[LSB +: 2]),
            .ga_chan          (ga_rgb[LSB +: 2]),
            .chan_out         (mix_out[ch])
        );
    end

    assign r_out = mix_out[0];
    assign g_out = mix_out[1];
    assign b_out = mix_out[2];

endmodule

`default_nettype wire

// ==== verification/gx_video_tests.svh ====
`ifndef GX_VIDEO_TESTS_SVH
`define GX_VIDEO_TESTS_SVH

// ------------------------------------------------------------
// Directed tests, called in order from the testbench
// ------------------------------------------------------------

// Reset values, classic colour path, black border
task automatic reset_passthrough();
    logic [31:0] word;
    int          i;
    check_val("asic_ram_rd", int'(asic_ram_rd), 0);
    check_val("sync_filter", int'(sync_filter), 0);
    check_val("sprite_active_out", int'(sprite_active_out), 0);
    check_black();
    for (i = 0; i < 4; i++) begin
        word   = $random(seed);
        ga_rgb = word[5:0];
        set_crtc(14'h0040 + 14'(i), 5'd1, 1'b1);
        wait_beats(2);
        check_mix(MIX_PASS, 1'b0);
    end
    set_crtc(14'h0040, 5'd1, 1'b0);  // Border
    wait_beats(2);
    check_black();
    report_test("reset_passthrough");
endtask

// Palette lookup with the RAM pens selected
task automatic palette_mode();
    logic [31:0] word;
    plus_mode = 1'b1;
    mode_write(8'h20);               // Config, nonzero
    mode_write(ASIC_MODE_PALETTE);
    mode_write(8'h01);               // MRER bit 0
    word       = $random(seed);
    asic_ram_q = word[7:0];
    ga_rgb     = word[13:8];
    set_crtc(14'h0123, 5'd5, 1'b1);
    wait_beats(1);
    check_val("asic_ram_rd", int'(asic_ram_rd), 1);
    check_val("asic_ram_addr", int'(asic_ram_addr), pen_addr_ref(14'h0123, 5'd5));
    @(negedge clk_sys);
    check_val("asic_ram_rd", int'(asic_ram_rd), 0);  // One clock only
    wait_beats(2);
    check_mix(MIX_PALETTE, 1'b0);
    report_test("palette_mode");
endtask

// Blend, then sprite priority in and out of the window
task automatic blend_and_sprite_mix();
    logic [31:0] word;
    int          i;
    mode_write(ASIC_MODE_BLEND);
    for (i = 0; i < 3; i++) begin
        word       = $random(seed);
        asic_ram_q = word[7:0];
        ga_rgb     = word[13:8];
        wait_beats(2);
        check_mix(MIX_BLEND, 1'b0);
    end
    mode_write(ASIC_MODE_SPRITE);
    set_crtc({SPRITE_PAGE, 10'h0C5}, 5'd2, 1'b1);
    wait_beats(2);
    check_mix(MIX_SPRITE, 1'b1);
    set_crtc(14'h0123, 5'd2, 1'b1);  // Outside the sprite page
    wait_beats(2);
    check_mix(MIX_SPRITE, 1'b0);
    report_test("blend_and_sprite_mix");
endtask

// Strap low keeps the classic path whatever the CPU writes
task automatic plus_strap_low();
    logic [31:0] word;
    int          clocks;
    plus_mode = 1'b0;
    set_crtc(14'h0123, 5'd5, 1'b0);
    @(negedge clk_sys);
    mode_write(ASIC_MODE_PALETTE);
    word       = $random(seed);
    ga_rgb     = word[5:0];
    asic_ram_q = word[15:8];
    set_crtc(14'h0123, 5'd5, 1'b1);
    for (clocks = 0; clocks < 8; clocks++) begin
        @(negedge clk_sys);
        checks_run++;
        assert (!asic_ram_rd) else begin
            $display("Palette read strobe pulsed at %0t ns with the Plus strap low", $time);
            record_failure();
        end
    end
    check_mix(MIX_PASS, 1'b0);
    check_val("sync_filter", int'(sync_filter), 0);
    report_test("plus_strap_low");
endtask

// Window flag and id, cleared by the border
task automatic sprite_window_flag();
    logic [31:0] word;
    logic [3:0]  id;
    int          i;
    for (i = 0; i < 3; i++) begin
        word = $random(seed);
        id   = word[3:0];
        set_crtc({SPRITE_PAGE, id, 6'h15}, 5'd0, 1'b1);
        wait_beats(2);
        check_val("sprite_active_out", int'(sprite_active_out), 1);
        check_val("sprite_id_out", int'(sprite_id_out), int'(id));
        set_crtc({SPRITE_PAGE, id, 6'h15}, 5'd0, 1'b0);
        wait_beats(1);
        check_val("sprite_active_out", int'(sprite_active_out), 0);
        check_val("sprite_id_out", int'(sprite_id_out), 0);
    end
    set_crtc({4'h7, 4'h9, 6'h00}, 5'd0, 1'b1);
    wait_beats(2);
    check_val("sprite_active_out", int'(sprite_active_out), 0);
    report_test("sprite_window_flag");
endtask

// CRTC-derived syncs, then the ASIC set once enabled
task automatic sync_selection();
    logic [31:0] word;
    crtc.hsync = 1'b1;
    crtc.vsync = 1'b0;
    set_crtc(14'h0000, 5'd0, 1'b1);
    wait_beats(2);
    check_val("sync_out", int'(sync_out), int'(crtc_sync_ref(crtc)));
    check_val("sync_filter", int'(sync_filter), 0);
    crtc.hsync = 1'b0;
    crtc.vsync = 1'b1;
    set_crtc(14'h0000, 5'd3, 1'b0);
    wait_beats(2);
    check_val("sync_out", int'(sync_out), int'(crtc_sync_ref(crtc)));
    plus_mode = 1'b1;
    mode_write(ASIC_MODE_PALETTE);
    word         = $random(seed);
    asic_sync_in = word[3:0];
    wait_beats(2);
    check_val("sync_out", int'(sync_out), int'(asic_sync_in));
    check_val("sync_filter", int'(sync_filter), 1);
    report_test("sync_selection");
endtask

`endif

// ==== verification/gx_video_tb.sv ====
`default_nettype none

module gx_video_tb
    import gx_video_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CHANNEL_W       = 4;
    localparam int TEST_COUNT      = 6;
    localparam int CLOCKS_PER_TEST = 250;  // Longest test stays under 100 clocks
    localparam int TIMEOUT_CYCLES  = TEST_COUNT * CLOCKS_PER_TEST + 500;  // Reset and margin

    logic                  clk_sys = 1'b0;
    logic                  cclk_en = 1'b0;  // Pixel enable, every second clock
    logic                  reset;
    logic                  plus_mode;
    cpu_wr_t               cpu;
    crtc_beat_t            crtc;
    rgb2_t                 ga_rgb;
    sync_t                 asic_sync_in;
    logic [7:0]            asic_ram_q;
    logic [CHANNEL_W-1:0]  r_out;
    logic [CHANNEL_W-1:0]  g_out;
    logic [CHANNEL_W-1:0]  b_out;
    logic                  sprite_active_out;
    logic [3:0]            sprite_id_out;
    sync_t                 sync_out;
    logic                  sync_filter;
    logic [PAL_ADDR_W-1:0] asic_ram_addr;
    logic                  asic_ram_rd;

    int seed;
    int cycle_count  = 0;
    int tests_run    = 0;
    int checks_run   = 0;
    int test_errors  = 0;
    int total_errors = 0;

    always #2 clk_sys = !clk_sys;  // 4 ns period

    always @(negedge clk_sys) cclk_en <= !cclk_en;

    gx_video_top #(
        .CHANNEL_W (CHANNEL_W)
    ) u_dut (
        .clk_sys           (clk_sys),
        .reset             (reset),
        .plus_mode         (plus_mode),
        .cclk_en           (cclk_en),
        .cpu               (cpu),
        .crtc              (crtc),
        .ga_rgb            (ga_rgb),
        .asic_sync_in      (asic_sync_in),
        .asic_ram_q        (asic_ram_q),
        .r_out             (r_out),
        .g_out             (g_out),
        .b_out             (b_out),
        .sprite_active_out (sprite_active_out),
        .sprite_id_out     (sprite_id_out),
        .sync_out          (sync_out),
        .sync_filter       (sync_filter),
        .asic_ram_addr     (asic_ram_addr),
        .asic_ram_rd       (asic_ram_rd)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic int mix_ref(input mix_sel_t mode, input logic in_window,
                                   input int pal, input int ga);
        case (mode)
            MIX_PALETTE: return pal;
            MIX_SPRITE:  return in_window ? pal : ga;  // RAM colour only in the window
            MIX_BLEND:   return (pal + ga) / 2;
            default:     return ga;                    // Zero-extended gate array
        endcase
    endfunction

    // Pen address, row bits above the low address bits
    function automatic int pen_addr_ref(input logic [MA_W-1:0] ma, input logic [RA_W-1:0] ra);
        return int'({ra[2:0], ma[1:0]});
    endfunction

    function automatic sync_t crtc_sync_ref(input crtc_beat_t beat);
        sync_t s;
        s.hsync  = beat.hsync;
        s.vsync  = beat.vsync;
        s.hblank = !beat.de;
        s.vblank = (beat.ra == 5'd0);
        return s;
    endfunction

    // ------------------------------------------------------------
    // Drive and check helpers
    // ------------------------------------------------------------
    task automatic record_failure();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_val(input string name, input int got, input int expected);
        checks_run++;
        assert (got == expected) else begin
            $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
            record_failure();
        end
    endtask

    // Expected colour from the held RAM byte and gate-array colour
    task automatic check_mix(input mix_sel_t mode, input logic in_window);
        check_val("r_out", int'(r_out),
                  mix_ref(mode, in_window, int'(asic_ram_q[1:0]), int'(ga_rgb.r)));
        check_val("g_out", int'(g_out),
                  mix_ref(mode, in_window, int'(asic_ram_q[3:2]), int'(ga_rgb.g)));
        check_val("b_out", int'(b_out),
                  mix_ref(mode, in_window, int'(asic_ram_q[5:4]), int'(ga_rgb.b)));
    endtask

    task automatic check_black();
        check_val("r_out", int'(r_out), 0);
        check_val("g_out", int'(g_out), 0);
        check_val("b_out", int'(b_out), 0);
    endtask

    // Returns on the falling edge after the last beat
    task automatic wait_beats(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk_sys);
            if (cclk_en) seen++;
        end
        @(negedge clk_sys);
    endtask

    task automatic set_crtc(input logic [MA_W-1:0] ma, input logic [RA_W-1:0] ra,
                            input logic de);
        crtc.ma = ma;
        crtc.ra = ra;
        crtc.de = de;
    endtask

    // Single-cycle write to the 0xBC page, even address
    task automatic mode_write(input logic [7:0] data);
        cpu.wr   = 1'b1;
        cpu.addr = {CRTC_PAGE, 8'h00};
        cpu.data = data;
        @(negedge clk_sys);
        cpu.wr   = 1'b0;
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failed checks", name, test_errors);
        end
        tests_run++;
        test_errors = 0;
    endtask

    `include "gx_video_tests.svh"

    // Run limit
    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clocks", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed         = 32'h8ab6_2269;
        reset        = 1'b1;
        plus_mode    = 1'b0;
        cpu          = '0;
        crtc         = '0;
        ga_rgb       = '0;
        asic_sync_in = '0;
        asic_ram_q   = 8'h00;
        repeat (3) @(negedge clk_sys);
        reset = 1'b0;

        reset_passthrough();
        palette_mode();
        blend_and_sprite_mix();
        plus_strap_low();
        sprite_window_flag();
        sync_selection();

        $display("%0d tests, %0d checks, %0d failed", tests_run, checks_run, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+verification
common/gx_video_pkg.sv
src/mode_decoder.sv
src/sprite_window.sv
src/sync_select.sv
mixer/palette_fetch.sv
mixer/channel_mixer.sv
src/gx_video_top.sv
verification/gx_video_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module gx_video_tb -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/Vgx_video_tb)"
echo "$sim_output"

grep -qx "TESTS PASSED" <<< "$sim_output" \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
